// File: common/ppu_pkg.sv
package ppu_pkg;

  // ============================================================
  // Display modes
  // ============================================================
  typedef enum logic [1:0] {
    mode_hblank = 2'd0,
    mode_vblank = 2'd1,
    mode_oam    = 2'd2,
    mode_draw   = 2'd3
  } ppu_mode_t;

  // ============================================================
  // Line and frame timing
  // ============================================================
  localparam logic [8:0] cycles_per_line = 9'd456;
  localparam logic [7:0] lines_per_frame = 8'd154;
  localparam logic [7:0] visible_lines   = 8'd144;
  localparam logic [8:0] mode2_len       = 9'd80;
  localparam logic [8:0] mode3_len       = 9'd172;
  localparam logic [7:0] screen_width    = 8'd160;

  // ============================================================
  // Address map
  // ============================================================
  localparam logic [15:0] vram_start = 16'h8000;
  localparam logic [15:0] vram_end   = 16'h9FFF;
  localparam logic [15:0] reg_base   = 16'hFF40;
  localparam int          vram_aw    = 13;
  localparam int          fifo_depth = 16;

  // Tile maps, as offsets into video memory
  localparam logic [12:0] map_base_lo = 13'h1800;
  localparam logic [12:0] map_base_hi = 13'h1C00;

  // Register offsets from reg_base
  localparam logic [2:0] reg_lcdc = 3'd0;
  localparam logic [2:0] reg_stat = 3'd1;
  localparam logic [2:0] reg_scy  = 3'd2;
  localparam logic [2:0] reg_scx  = 3'd3;
  localparam logic [2:0] reg_ly   = 3'd4;
  localparam logic [2:0] reg_lyc  = 3'd5;
  localparam logic [2:0] reg_bgp  = 3'd7;

endpackage

// File: ppu/ppu_mode_seq.sv
`timescale 1ns/1ps

module ppu_mode_seq import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  output logic [8:0] dot,
  output logic [7:0] ly,
  output ppu_mode_t  mode
);

  logic line_end;

  assign line_end = (dot == cycles_per_line - 9'd1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot  <= '0;
      ly   <= '0;
      mode <= mode_oam;
    end else if (line_end) begin
      dot <= '0;
      if (ly == lines_per_frame - 8'd1) begin
        // Back to the top of the frame
        ly   <= '0;
        mode <= mode_oam;
      end else begin
        ly <= ly + 8'd1;
        if (ly == visible_lines - 8'd1) begin
          mode <= mode_vblank;
        end else if (mode != mode_vblank) begin
          mode <= mode_oam;
        end
      end
    end else begin
      dot <= dot + 9'd1;
      // Mode 3 starts at dot 80, mode 0 at dot 252
      if (mode == mode_oam && dot == mode2_len - 9'd1) begin
        mode <= mode_draw;
      end else if (mode == mode_draw && dot == mode2_len + mode3_len - 9'd1) begin
        mode <= mode_hblank;
      end
    end
  end

  // Drawing never happens during vblank lines
  assert property (@(posedge clk) disable iff (reset)
    (mode == mode_draw) |-> (ly < visible_lines));

endmodule

// File: ppu/vram_arbiter.sv
`timescale 1ns/1ps

module vram_arbiter import ppu_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  ppu_mode_t          mode,
  input  logic               fetch_req,
  input  logic [vram_aw-1:0] fetch_addr,
  output logic [7:0]         fetch_rdata,
  input  logic               cpu_req,
  input  logic               cpu_we,
  input  logic [vram_aw-1:0] cpu_addr,
  input  logic [7:0]         cpu_wdata,
  output logic [7:0]         cpu_rdata,
  output logic               cpu_done,
  output logic               cpu_blocked
);

  logic [7:0] mem [2**vram_aw];
  logic [7:0] rdata_q;
  logic       pending;
  logic       cpu_refuse;
  logic       cpu_want;
  logic       cpu_go;

  // CPU is locked out while the fetcher owns the line
  assign cpu_refuse = cpu_req && (mode == mode_draw);
  assign cpu_want   = pending || (cpu_req && !cpu_refuse);
  assign cpu_go     = cpu_want && !fetch_req;

  // Single port, fetcher first
  always_ff @(posedge clk) begin
    if (fetch_req) begin
      rdata_q <= mem[fetch_addr];
    end else if (cpu_go) begin
      if (cpu_we) begin
        mem[cpu_addr] <= cpu_wdata;
      end else begin
        rdata_q <= mem[cpu_addr];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending     <= 1'b0;
      cpu_done    <= 1'b0;
      cpu_blocked <= 1'b0;
    end else begin
      pending     <= cpu_want && fetch_req;
      cpu_done    <= cpu_go || cpu_refuse;
      cpu_blocked <= cpu_refuse;
    end
  end

  assign fetch_rdata = rdata_q;
  assign cpu_rdata   = rdata_q;

  assert property (@(posedge clk) disable iff (reset)
    fetch_req |-> (mode == mode_draw));

  // Bus slave keeps at most one access outstanding
  assert property (@(posedge clk) disable iff (reset)
    cpu_req |-> !pending);

endmodule

// File: ppu/bg_fetcher.sv
`timescale 1ns/1ps

module bg_fetcher import ppu_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  ppu_mode_t          mode,
  input  logic [8:0]         dot,
  input  logic [7:0]         ly,
  input  logic [7:0]         lcdc,
  input  logic [7:0]         scy,
  input  logic [7:0]         scx,
  output logic               fetch_req,
  output logic [vram_aw-1:0] fetch_addr,
  input  logic [7:0]         fetch_rdata,
  output logic               push,
  output logic [1:0]         push_idx,
  input  logic               free_ge8
);

  logic [7:0] line_y;
  logic [4:0] tile_col;
  logic [1:0] fcnt;
  logic [7:0] tile_num;
  logic [7:0] plane_lo;
  logic [7:0] buf_lo;
  logic [7:0] buf_hi;
  logic       buf_full;
  logic [7:0] sh_lo;
  logic [7:0] sh_hi;
  logic [2:0] sh_cnt;
  logic       active;
  logic       start;
  logic       load;

  assign line_y = ly + scy;
  assign active = (mode == mode_draw);
  assign start  = active && (dot == mode2_len);

  // ============================================================
  // Fetch side: map byte, low plane, high plane
  // ============================================================
  assign fetch_req = active && !start && (fcnt != 2'd3) && !(fcnt == 2'd0 && buf_full);

  always_comb begin
    case (fcnt)
      2'd0:    fetch_addr = (lcdc[3] ? map_base_hi : map_base_lo) +
                            {3'b000, line_y[7:3], tile_col};
      // Map byte arrives this cycle
      2'd1:    fetch_addr = {1'b0, fetch_rdata, line_y[2:0], 1'b0};
      default: fetch_addr = {1'b0, tile_num, line_y[2:0], 1'b1};
    endcase
  end

  // ============================================================
  // Push side: eight indices per tile, MSB first
  // ============================================================
  assign load     = active && !start && (sh_cnt == 3'd0) && buf_full && free_ge8;
  assign push     = active && !start && ((sh_cnt != 3'd0) || load);
  assign push_idx = (sh_cnt != 3'd0) ? {sh_hi[7], sh_lo[7]} : {buf_hi[7], buf_lo[7]};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tile_col <= '0;
      fcnt     <= '0;
      buf_full <= 1'b0;
      sh_cnt   <= '0;
    end else if (start) begin
      // Coarse scroll only
      tile_col <= scx[7:3];
      fcnt     <= '0;
      buf_full <= 1'b0;
      sh_cnt   <= '0;
    end else if (active) begin
      if (load) begin
        buf_full <= 1'b0;
        sh_cnt   <= 3'd7;
      end else if (sh_cnt != 3'd0) begin
        sh_cnt <= sh_cnt - 3'd1;
      end
      case (fcnt)
        2'd0: if (!buf_full) fcnt <= 2'd1;
        2'd1: fcnt <= 2'd2;
        2'd2: fcnt <= 2'd3;
        default: begin
          fcnt     <= 2'd0;
          buf_full <= 1'b1;
          tile_col <= tile_col + 5'd1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (active && !start) begin
      if (fcnt == 2'd1) tile_num <= fetch_rdata;
      if (fcnt == 2'd2) plane_lo <= fetch_rdata;
      if (fcnt == 2'd3) begin
        buf_lo <= plane_lo;
        buf_hi <= fetch_rdata;
      end
      if (load) begin
        sh_lo <= {buf_lo[6:0], 1'b0};
        sh_hi <= {buf_hi[6:0], 1'b0};
      end else if (sh_cnt != 3'd0) begin
        sh_lo <= {sh_lo[6:0], 1'b0};
        sh_hi <= {sh_hi[6:0], 1'b0};
      end
    end
  end

endmodule

// File: ppu/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic       push,
  input  logic [1:0] push_idx,
  input  logic       pop,
  output logic [1:0] pop_idx,
  output logic       empty,
  output logic       free_ge8
);

  logic [1:0]                    mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;
  logic [$clog2(fifo_depth):0]   count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_idx;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + ($bits(count))'(push) - ($bits(count))'(pop);
    end
  end

  assign pop_idx  = mem[rd_ptr];
  assign empty    = (count == '0);
  assign free_ge8 = (int'(count) <= fifo_depth - 8);

  assert property (@(posedge clk) disable iff (reset)
    push |-> (int'(count) < fifo_depth));

  assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

endmodule

// File: ppu/pixel_output.sv
`timescale 1ns/1ps

module pixel_output import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  ppu_mode_t  mode,
  input  logic [7:0] ly,
  input  logic [7:0] bgp,
  output logic       flush,
  output logic       pop,
  input  logic [1:0] pop_idx,
  input  logic       empty,
  output logic       pixel_valid,
  output logic [7:0] pixel_x,
  output logic [7:0] pixel_y,
  output logic [1:0] pixel_shade
);

  ppu_mode_t  mode_q;
  logic [7:0] x_cnt;

  // Clear leftovers from the previous line as OAM scan begins
  assign flush = (mode == mode_oam) && (mode_q != mode_oam);
  assign pop   = (mode == mode_draw) && !empty && (x_cnt < screen_width);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode_q      <= mode_vblank;
      x_cnt       <= '0;
      pixel_valid <= 1'b0;
    end else begin
      mode_q      <= mode;
      pixel_valid <= pop;
      if (flush) begin
        x_cnt <= '0;
      end else if (pop) begin
        x_cnt <= x_cnt + 8'd1;
      end
    end
  end

  // Index n picks BGP bits 2n+1..2n
  always_ff @(posedge clk) begin
    if (pop) begin
      pixel_x     <= x_cnt;
      pixel_y     <= ly;
      pixel_shade <= bgp[{pop_idx, 1'b0} +: 2];
    end
  end

endmodule

// File: ppu/ppu_bus_slave.sv
`timescale 1ns/1ps

module ppu_bus_slave import ppu_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [15:0]        wb_adr,
  input  logic [7:0]         wb_dat_w,
  output logic [7:0]         wb_dat_r,
  output logic               wb_ack,
  input  ppu_mode_t          mode,
  input  logic [7:0]         ly,
  output logic [7:0]         lcdc,
  output logic [7:0]         scy,
  output logic [7:0]         scx,
  output logic [7:0]         bgp,
  output logic               cpu_req,
  output logic               cpu_we,
  output logic [vram_aw-1:0] cpu_addr,
  output logic [7:0]         cpu_wdata,
  input  logic [7:0]         cpu_rdata,
  input  logic               cpu_done,
  input  logic               cpu_blocked
);

  logic       is_vram;
  logic       is_reg;
  logic       reg_cycle;
  logic       reg_ack;
  logic       vram_busy;
  logic [7:0] lyc;
  logic [7:0] stat;
  logic [7:0] reg_rdata;
  logic [7:0] rdata_q;

  // ============================================================
  // Address decode and VRAM request
  // ============================================================
  assign is_vram   = wb_adr inside {[vram_start:vram_end]};
  assign is_reg    = (wb_adr[15:3] == reg_base[15:3]);
  assign reg_cycle = wb_cyc && wb_stb && !is_vram && !reg_ack;

  assign cpu_req   = wb_cyc && wb_stb && is_vram && !vram_busy;
  assign cpu_we    = wb_we;
  assign cpu_addr  = vram_aw'(wb_adr - vram_start);
  assign cpu_wdata = wb_dat_w;

  // ============================================================
  // Register read mux
  // ============================================================
  assign stat = {1'b1, 4'b0000, (ly == lyc), mode};

  always_comb begin
    reg_rdata = 8'hFF;
    if (is_reg) begin
      case (wb_adr[2:0])
        reg_lcdc: reg_rdata = lcdc;
        reg_stat: reg_rdata = stat;
        reg_scy:  reg_rdata = scy;
        reg_scx:  reg_rdata = scx;
        reg_ly:   reg_rdata = ly;
        reg_lyc:  reg_rdata = lyc;
        reg_bgp:  reg_rdata = bgp;
        default:  reg_rdata = 8'hFF;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_ack   <= 1'b0;
      vram_busy <= 1'b0;
      lcdc      <= 8'h00;
      scy       <= 8'h00;
      scx       <= 8'h00;
      lyc       <= 8'h00;
      bgp       <= 8'hE4;
    end else begin
      reg_ack <= reg_cycle;
      if (cpu_req) begin
        vram_busy <= 1'b1;
      end else if (cpu_done) begin
        vram_busy <= 1'b0;
      end
      // LY and STAT are read only
      if (reg_cycle && wb_we && is_reg) begin
        case (wb_adr[2:0])
          reg_lcdc: lcdc <= wb_dat_w;
          reg_scy:  scy  <= wb_dat_w;
          reg_scx:  scx  <= wb_dat_w;
          reg_lyc:  lyc  <= wb_dat_w;
          reg_bgp:  bgp  <= wb_dat_w;
          default:  ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reg_cycle) begin
      rdata_q <= reg_rdata;
    end
  end

  assign wb_ack   = reg_ack || cpu_done;
  assign wb_dat_r = cpu_done ? (cpu_blocked ? 8'hFF : cpu_rdata) : rdata_q;

  // One-cycle ack, from either path
  assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack);

endmodule

// File: src/ppu_top.sv
`timescale 1ns/1ps

module ppu_top import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [15:0] wb_adr,
  input  logic [7:0]  wb_dat_w,
  output logic [7:0]  wb_dat_r,
  output logic        wb_ack,
  output logic        pixel_valid,
  output logic [7:0]  pixel_x,
  output logic [7:0]  pixel_y,
  output logic [1:0]  pixel_shade
);

  ppu_mode_t          mode;
  logic [8:0]         dot;
  logic [7:0]         ly;
  logic [7:0]         lcdc;
  logic [7:0]         scy;
  logic [7:0]         scx;
  logic [7:0]         bgp;
  logic               fetch_req;
  logic [vram_aw-1:0] fetch_addr;
  logic [7:0]         fetch_rdata;
  logic               cpu_req;
  logic               cpu_we;
  logic [vram_aw-1:0] cpu_addr;
  logic [7:0]         cpu_wdata;
  logic [7:0]         cpu_rdata;
  logic               cpu_done;
  logic               cpu_blocked;
  logic               push;
  logic [1:0]         push_idx;
  logic               free_ge8;
  logic               flush;
  logic               pop;
  logic [1:0]         pop_idx;
  logic               empty;

  ppu_mode_seq mode_seq_i (
    .clk   (clk),
    .reset (reset),
    .dot   (dot),
    .ly    (ly),
    .mode  (mode)
  );

  ppu_bus_slave bus_slave_i (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .mode        (mode),
    .ly          (ly),
    .lcdc        (lcdc),
    .scy         (scy),
    .scx         (scx),
    .bgp         (bgp),
    .cpu_req     (cpu_req),
    .cpu_we      (cpu_we),
    .cpu_addr    (cpu_addr),
    .cpu_wdata   (cpu_wdata),
    .cpu_rdata   (cpu_rdata),
    .cpu_done    (cpu_done),
    .cpu_blocked (cpu_blocked)
  );

  vram_arbiter arbiter_i (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_rdata (fetch_rdata),
    .cpu_req     (cpu_req),
    .cpu_we      (cpu_we),
    .cpu_addr    (cpu_addr),
    .cpu_wdata   (cpu_wdata),
    .cpu_rdata   (cpu_rdata),
    .cpu_done    (cpu_done),
    .cpu_blocked (cpu_blocked)
  );

  bg_fetcher fetcher_i (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .dot         (dot),
    .ly          (ly),
    .lcdc        (lcdc),
    .scy         (scy),
    .scx         (scx),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_rdata (fetch_rdata),
    .push        (push),
    .push_idx    (push_idx),
    .free_ge8    (free_ge8)
  );

  pixel_fifo fifo_i (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .push     (push),
    .push_idx (push_idx),
    .pop      (pop),
    .pop_idx  (pop_idx),
    .empty    (empty),
    .free_ge8 (free_ge8)
  );

  pixel_output output_i (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .ly          (ly),
    .bgp         (bgp),
    .flush       (flush),
    .pop         (pop),
    .pop_idx     (pop_idx),
    .empty       (empty),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_shade (pixel_shade)
  );

endmodule

// File: bench/ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb;

  // ============================================================
  // Bus address map
  // ============================================================
  localparam logic [15:0] addr_lcdc = 16'hFF40;
  localparam logic [15:0] addr_stat = 16'hFF41;
  localparam logic [15:0] addr_scy  = 16'hFF42;
  localparam logic [15:0] addr_scx  = 16'hFF43;
  localparam logic [15:0] addr_ly   = 16'hFF44;
  localparam logic [15:0] addr_lyc  = 16'hFF45;
  localparam logic [15:0] addr_bgp  = 16'hFF47;
  localparam int          frame_limit = 80000;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [7:0]  wb_dat_w;
  logic [7:0]  wb_dat_r;
  logic        wb_ack;
  logic        pixel_valid;
  logic [7:0]  pixel_x;
  logic [7:0]  pixel_y;
  logic [1:0]  pixel_shade;

  int    seed = 32'h7f5b_32d3;
  int    cycle = 0;
  string test_name;
  int    test_errs;
  int    tests_run;
  int    tests_failed;
  logic  hung;

  // Reference copy of video memory
  logic [7:0] mirror [8192];

  // Captured pixels, indexed by y then x
  logic       cap_on;
  logic       cap_armed;
  logic [1:0] cap_shade [256][256];
  int         cap_count [256];
  bit         cap_xbad [256];

  ppu_top ppu_top_i (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_shade (pixel_shade)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Pixel monitor, clears its tables when capture starts
  always @(negedge clk) begin
    if (!cap_on) begin
      cap_armed = 1'b0;
    end else begin
      if (!cap_armed) begin
        for (int i = 0; i < 256; i++) begin
          cap_count[8'(i)] = 0;
          cap_xbad[8'(i)]  = 1'b0;
        end
        cap_armed = 1'b1;
      end
      if (pixel_valid) begin
        if (int'(pixel_x) != cap_count[pixel_y]) cap_xbad[pixel_y] = 1'b1;
        cap_shade[pixel_y][pixel_x] = pixel_shade;
        cap_count[pixel_y] = cap_count[pixel_y] + 1;
      end
    end
  end

  // ============================================================
  // Reporting
  // ============================================================
  task automatic flag_error(input string msg);
    $display("Error in %s: %s", test_name, msg);
    test_errs++;
  endtask

  task automatic log_mismatch(input string what, input logic [7:0] exp, input logic [7:0] act);
    $display("Fail %s: %s expected 0x%02h actual 0x%02h", test_name, what, exp, act);
    test_errs++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic close_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("%s: passed", test_name);
    end else begin
      $display("%s: failed with %0d errors", test_name, test_errs);
      tests_failed++;
    end
  endtask

  function automatic logic [7:0] rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic logic [12:0] rand_offset();
    int r;
    r = $random(seed);
    return r[12:0];
  endfunction

  // ============================================================
  // Wishbone master
  // ============================================================
  task automatic bus_cycle(input logic we, input logic [15:0] addr,
                           input logic [7:0] wdata, output logic [7:0] rdata);
    int   n;
    logic got;
    rdata = 8'hFF;
    got   = 1'b0;
    n     = 0;
    if (!hung) begin
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = addr;
      wb_dat_w = wdata;
      while (!got && n < 20) begin
        @(negedge clk);
        n++;
        if (wb_ack) begin
          got   = 1'b1;
          rdata = wb_dat_r;
        end
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      if (!got) begin
        flag_error($sformatf("no ack within 20 cycles at address 0x%04h", addr));
        hung = 1'b1;
      end
    end
  endtask

  task automatic wb_write(input logic [15:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input logic [15:0] addr, output logic [7:0] data);
    bus_cycle(1'b0, addr, 8'h00, data);
  endtask

  task automatic vram_store(input logic [12:0] off, input logic [7:0] data);
    wb_write(16'h8000 + {3'b000, off}, data);
    mirror[off] = data;
  endtask

  task automatic vram_load(input logic [12:0] off, output logic [7:0] data);
    wb_read(16'h8000 + {3'b000, off}, data);
  endtask

  task automatic write_read_reg(input logic [15:0] addr, input logic [7:0] value,
                                input string what);
    logic [7:0] v;
    wb_write(addr, value);
    wb_read(addr, v);
    if (v !== value) log_mismatch(what, value, v);
  endtask

  // ============================================================
  // Polling with timeouts
  // ============================================================
  task automatic wait_mode(input logic [1:0] m);
    logic [7:0] v;
    int         t0;
    logic       done;
    t0   = cycle;
    done = 1'b0;
    while (!done && !hung) begin
      wb_read(addr_stat, v);
      if (v[1:0] == m) begin
        done = 1'b1;
      end else if (cycle - t0 > frame_limit) begin
        flag_error($sformatf("STAT never showed mode %0d", m));
        hung = 1'b1;
      end
    end
  endtask

  task automatic wait_ly(input logic [7:0] target);
    logic [7:0] v;
    int         t0;
    logic       done;
    t0   = cycle;
    done = 1'b0;
    while (!done && !hung) begin
      wb_read(addr_ly, v);
      if (v == target) begin
        done = 1'b1;
      end else if (cycle - t0 > frame_limit) begin
        flag_error($sformatf("LY never reached %0d", target));
        hung = 1'b1;
      end
    end
  endtask

  // Back-to-back reads, so the sample grid is fixed
  task automatic next_ly(input logic [7:0] prev, output logic [7:0] v, output int t);
    int t0;
    t0 = cycle;
    v  = prev;
    t  = cycle;
    while (v == prev && !hung) begin
      wb_read(addr_ly, v);
      t = cycle;
      if (v == prev && cycle - t0 > 1000) begin
        flag_error("LY stopped changing");
        hung = 1'b1;
      end
    end
  endtask

  // ============================================================
  // Reference model for the background
  // ============================================================
  function automatic logic [1:0] expected_shade(input int y, input int x, input logic [7:0] sx,
                                                input logic [7:0] sy, input logic hi,
                                                input logic [7:0] pal);
    int         line_y;
    int         col;
    int         map_off;
    int         data_off;
    int         bit_pos;
    int         idx;
    logic [7:0] lo_b;
    logic [7:0] hi_b;
    line_y   = (y + int'(sy)) % 256;
    col      = (int'(sx) / 8 + x / 8) % 32;
    map_off  = (hi ? 32'h1C00 : 32'h1800) + (line_y / 8) * 32 + col;
    data_off = int'(mirror[13'(map_off)]) * 16 + (line_y % 8) * 2;
    lo_b     = mirror[13'(data_off)];
    hi_b     = mirror[13'(data_off + 1)];
    bit_pos  = 7 - x % 8;
    idx      = 2 * int'(hi_b[3'(bit_pos)]) + int'(lo_b[3'(bit_pos)]);
    return pal[3'(2 * idx) +: 2];
  endfunction

  task automatic capture_frame();
    cap_on = 1'b1;
    wait_ly(8'd0);
    wait_ly(8'd144);
    cap_on = 1'b0;
  endtask

  task automatic check_line(input int y, input logic [7:0] sx, input logic [7:0] sy,
                            input logic hi, input logic [7:0] pal);
    int         bad;
    logic [1:0] exp_s;
    bad = 0;
    if (cap_count[8'(y)] != 160) begin
      $display("Fail %s: pixels on line %0d expected 160 actual %0d",
               test_name, y, cap_count[8'(y)]);
      test_errs++;
    end
    if (cap_xbad[8'(y)]) flag_error($sformatf("x did not run 0 to 159 on line %0d", y));
    for (int x = 0; x < 160; x++) begin
      exp_s = expected_shade(y, x, sx, sy, hi, pal);
      if (cap_shade[8'(y)][8'(x)] !== exp_s) begin
        if (bad == 0) begin
          $display("Fail %s: shade at line %0d x %0d expected %0d actual %0d",
                   test_name, y, x, exp_s, cap_shade[8'(y)][8'(x)]);
        end
        bad++;
      end
    end
    if (bad > 0) begin
      test_errs++;
      if (bad > 1) $display("Error in %s: %0d shades wrong on line %0d", test_name, bad, y);
    end
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic reset_and_registers();
    logic [7:0] v;
    start_test("reset_and_registers");
    wb_read(addr_ly, v);
    if (v !== 8'h00) log_mismatch("LY after reset", 8'h00, v);
    // Bit 7 set, LY equals LYC, mode 2
    wb_read(addr_stat, v);
    if (v !== 8'h86) log_mismatch("STAT after reset", 8'h86, v);
    wb_read(addr_bgp, v);
    if (v !== 8'hE4) log_mismatch("BGP after reset", 8'hE4, v);
    write_read_reg(addr_lcdc, 8'h91, "LCDC");
    write_read_reg(addr_scy, 8'h33, "SCY");
    write_read_reg(addr_scx, 8'h48, "SCX");
    write_read_reg(addr_lyc, 8'h77, "LYC");
    write_read_reg(addr_bgp, 8'h1B, "BGP");
    wb_write(addr_ly, 8'h5A);
    wb_read(addr_ly, v);
    if (v == 8'h5A) flag_error("LY took the written value 0x5A");
    close_test();
  endtask

  task automatic vram_in_vblank();
    logic [12:0] off;
    logic [7:0]  v;
    start_test("vram_in_vblank");
    wait_mode(2'd1);
    for (int i = 0; i < 8; i++) begin
      off = rand_offset();
      // Both ends of the window as well
      if (i == 0) off = 13'h0000;
      if (i == 1) off = 13'h1FFF;
      vram_store(off, rand_byte());
      vram_load(off, v);
      if (v !== mirror[off]) begin
        log_mismatch($sformatf("VRAM 0x%04h", 16'h8000 + {3'b000, off}), mirror[off], v);
      end
    end
    wb_read(16'hFF46, v);
    if (v !== 8'hFF) log_mismatch("unmapped 0xFF46", 8'hFF, v);
    close_test();
  endtask

  task automatic mode3_lock();
    logic [7:0] v;
    start_test("mode3_lock");
    wait_mode(2'd1);
    vram_store(13'h1F00, 8'hA5);
    wait_mode(2'd3);
    vram_load(13'h1F00, v);
    if (v !== 8'hFF) log_mismatch("read during mode 3", 8'hFF, v);
    wb_write(16'h9F00, 8'h5A);
    wait_mode(2'd1);
    vram_load(13'h1F00, v);
    if (v !== mirror[13'h1F00]) log_mismatch("VRAM 0x9F00 after refused write", 8'hA5, v);
    close_test();
  endtask

  task automatic line_timing();
    logic [7:0] v0;
    logic [7:0] v1;
    logic [7:0] v2;
    int         t1;
    int         t2;
    start_test("line_timing");
    wb_read(addr_ly, v0);
    next_ly(v0, v1, t1);
    next_ly(v1, v2, t2);
    if (t2 - t1 != 456) begin
      $display("Fail %s: cycles per line expected 456 actual %0d", test_name, t2 - t1);
      test_errs++;
    end
    wb_write(addr_lyc, 8'd20);
    wait_ly(8'd20);
    wb_read(addr_stat, v0);
    if (!v0[2]) log_mismatch("STAT bit 2 at LY 20", 8'h04, {5'b0, v0[2], 2'b00});
    wait_ly(8'd21);
    wb_read(addr_stat, v0);
    if (v0[2]) log_mismatch("STAT bit 2 at LY 21", 8'h00, {5'b0, v0[2], 2'b00});
    wait_ly(8'd153);
    next_ly(8'd153, v1, t1);
    if (v1 !== 8'd0) log_mismatch("LY after 153", 8'h00, v1);
    close_test();
  endtask

  task automatic pixel_stream();
    int         rows [3] = '{0, 10, 18};
    logic [7:0] v;
    start_test("pixel_stream");
    wait_ly(8'd144);
    // Tiles 0..15, then three map rows that point at them
    for (int t = 0; t < 256; t++) vram_store(13'(t), rand_byte());
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 32; c++) begin
        vram_store(13'(32'h1800 + rows[r] * 32 + c), rand_byte() & 8'h0F);
      end
    end
    wb_write(addr_scy, 8'd5);
    wb_write(addr_scx, 8'd16);
    wb_write(addr_lcdc, 8'h00);
    wb_write(addr_bgp, 8'h1B);
    wb_read(addr_ly, v);
    if (v < 8'd144) flag_error("scene load ran past the end of vblank");
    capture_frame();
    check_line(0, 8'd16, 8'd5, 1'b0, 8'h1B);
    check_line(77, 8'd16, 8'd5, 1'b0, 8'h1B);
    check_line(143, 8'd16, 8'd5, 1'b0, 8'h1B);
    close_test();
  endtask

  task automatic map_select();
    logic [7:0] lo;
    logic [7:0] v;
    start_test("map_select");
    wait_ly(8'd144);
    // Row 10 of the second map, never equal to the first
    for (int c = 0; c < 32; c++) begin
      lo = mirror[13'(32'h1800 + 320 + c)];
      vram_store(13'(32'h1C00 + 320 + c), 8'd15 - lo);
    end
    wb_write(addr_lcdc, 8'h08);
    wb_read(addr_ly, v);
    if (v < 8'd144) flag_error("map load ran past the end of vblank");
    capture_frame();
    check_line(77, 8'd16, 8'd5, 1'b1, 8'h1B);
    close_test();
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    reset        = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = 16'h0000;
    wb_dat_w     = 8'h00;
    cap_on       = 1'b0;
    hung         = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    test_errs    = 0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    reset_and_registers();
    if (!hung) vram_in_vblank();
    if (!hung) mode3_lock();
    if (!hung) line_timing();
    if (!hung) pixel_stream();
    if (!hung) map_select();

    $display("Tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/ppu_pkg.sv
ppu/ppu_mode_seq.sv
ppu/vram_arbiter.sv
ppu/bg_fetcher.sv
ppu/pixel_fifo.sv
ppu/pixel_output.sv
ppu/ppu_bus_slave.sv
src/ppu_top.sv
bench/ppu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ppu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
